// ==== source/conv_load_pkg.sv ====
package conv_load_pkg;

  // --------------------------------------------------
  // sizes
  // --------------------------------------------------
  localparam int DDR_WORD_W      = 512;  // one DDR beat
  localparam int PIXEL_W         = 8;    // mode 0 pixels only
  localparam int PIXELS_PER_HALF = 32;
  localparam int NUM_ROW_BUFS    = 3;
  localparam int BUF_ADR_W       = 12;   // 4096 words per row buffer
  localparam int DDR_ADR_W       = 16;
  localparam int INFO_FIFO_DEPTH = 16;

  // --------------------------------------------------
  // types
  // --------------------------------------------------
  typedef logic [$clog2(NUM_ROW_BUFS)-1:0] buf_idx_t;

  // job configuration, sampled on load_start
  // no count field may be zero
  typedef struct packed {
    logic [DDR_ADR_W-1:0] base_adr;  // first DDR word of the job
    logic [7:0]           rows;      // input rows
    logic [7:0]           nif;       // input feature maps per row
    logic [7:0]           words;     // 512-bit words per row and map
    logic [3:0]           spare;
  } load_cfg_t;

  // one entry per outstanding DDR read
  typedef struct packed {
    buf_idx_t             buf_idx;   // target row buffer
    logic [BUF_ADR_W-1:0] buf_adr;   // word address inside that buffer
    logic                 last;      // final word of the job
  } load_info_t;

  // one half of a stored word, 32 pixels
  typedef logic [PIXELS_PER_HALF*PIXEL_W-1:0] half_t;

endpackage

// ==== source/load_sequencer.sv ====
module load_sequencer (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                load_start,
  input  conv_load_pkg::load_cfg_t            load_cfg,
  input  logic                                ddr_ready,
  input  logic                                info_full,
  input  logic                                load_done,
  output logic                                load_busy,
  output logic                                ddr_rd_en,
  output logic [conv_load_pkg::DDR_ADR_W-1:0] ddr_rd_adr,
  output logic                                info_push,
  output conv_load_pkg::load_info_t           info_data
);
  import conv_load_pkg::*;

  load_cfg_t            cfg_q;
  logic                 busy_q;    // job open
  logic                 issuing;   // requests still to go out
  logic [7:0]           word_cnt;
  logic [7:0]           if_cnt;
  logic [7:0]           row_cnt;
  buf_idx_t             buf_sel;   // row_cnt mod 3
  logic [BUF_ADR_W-1:0] wr_ptr [NUM_ROW_BUFS];
  logic [DDR_ADR_W-1:0] adr_cnt;
  logic                 job_start;
  logic                 issue;
  logic                 word_last;
  logic                 if_last;
  logic                 row_last;

  // busy drops in the same cycle as the done pulse
  assign load_busy = busy_q && !load_done;

  assign job_start = load_start && !load_busy;  // start while busy is dropped

  assign word_last = (word_cnt == cfg_q.words - 8'd1);
  assign if_last   = (if_cnt == cfg_q.nif - 8'd1);
  assign row_last  = (row_cnt == cfg_q.rows - 8'd1);

  // one request per cycle, request and entry always together
  assign issue      = load_busy && issuing && ddr_ready && !info_full;
  assign ddr_rd_en  = issue;
  assign info_push  = issue;
  assign ddr_rd_adr = adr_cnt;

  always_comb
  begin
    info_data.buf_idx = buf_sel;
    info_data.buf_adr = wr_ptr[buf_sel];
    info_data.last    = word_last && if_last && row_last;
  end

  always_ff @(posedge clk)
  begin
    if (job_start)
      cfg_q <= load_cfg;
  end

  // --------------------------------------------------
  // job state
  // --------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      busy_q  <= 1'b0;
      issuing <= 1'b0;
    end
    else if (job_start)
    begin
      busy_q  <= 1'b1;
      issuing <= 1'b1;
    end
    else
    begin
      if (issue && info_data.last)
        issuing <= 1'b0;  // final request sent, wait for its data
      if (load_done)
        busy_q <= 1'b0;
    end
  end

  // --------------------------------------------------
  // row / feature / word walk
  // --------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (reset || job_start)
    begin
      word_cnt <= '0;
      if_cnt   <= '0;
      row_cnt  <= '0;
      buf_sel  <= '0;
      adr_cnt  <= reset ? '0 : load_cfg.base_adr;
      for (int i = 0; i < NUM_ROW_BUFS; i++)
        wr_ptr[i] <= '0;  // pointers restart every job
    end
    else if (issue)
    begin
      adr_cnt         <= adr_cnt + 1'b1;  // layout is row-major, so addresses just count
      wr_ptr[buf_sel] <= wr_ptr[buf_sel] + 1'b1;
      if (!word_last)
        word_cnt <= word_cnt + 8'd1;
      else
      begin
        word_cnt <= '0;
        if (!if_last)
          if_cnt <= if_cnt + 8'd1;
        else
        begin
          if_cnt  <= '0;
          row_cnt <= row_cnt + 8'd1;
          // next row goes to the next buffer
          buf_sel <= (buf_sel == buf_idx_t'(NUM_ROW_BUFS - 1)) ? '0 : buf_sel + 1'b1;
        end
      end
    end
  end

  // --------------------------------------------------
  // checks
  // --------------------------------------------------
  // done comes back only for an open job whose requests are all out
  a_done_after_last : assert property (@(posedge clk) disable iff (reset)
    load_done |-> busy_q && !issuing);

endmodule

// ==== source/load_info_fifo.sv ====
module load_info_fifo (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      push,
  input  conv_load_pkg::load_info_t push_data,
  input  logic                      pop,
  output conv_load_pkg::load_info_t head,
  output logic                      full,
  output logic                      empty
);
  import conv_load_pkg::*;

  load_info_t                           mem [INFO_FIFO_DEPTH];
  logic [$clog2(INFO_FIFO_DEPTH)-1:0]   wr_ptr;
  logic [$clog2(INFO_FIFO_DEPTH)-1:0]   rd_ptr;
  logic [$clog2(INFO_FIFO_DEPTH):0]     count;  // one extra bit for the full case

  assign head  = mem[rd_ptr];  // show-ahead
  assign full  = (count == INFO_FIFO_DEPTH);
  assign empty = (count == 0);

  always_ff @(posedge clk)
  begin
    if (push)
      mem[wr_ptr] <= push_data;
  end

  // --------------------------------------------------
  // pointers and occupancy
  // --------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;  // depth is a power of two, wraps by itself
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // both or neither
      endcase
    end
  end

  // the sequencer holds off on full, the bank only pops on returned data
  a_no_overflow : assert property (@(posedge clk) disable iff (reset)
    push |-> !full);

  a_no_underflow : assert property (@(posedge clk) disable iff (reset)
    pop |-> !empty);

endmodule

// ==== source/row_buffer_bank.sv ====
module row_buffer_bank (
  input  logic                                 clk,
  input  logic                                 reset,
  // returned DDR words
  input  logic                                 ddr_rd_valid,
  input  logic [conv_load_pkg::DDR_WORD_W-1:0] ddr_rd_data,
  // load-info FIFO head
  input  conv_load_pkg::load_info_t            info_head,
  input  logic                                 info_empty,
  output logic                                 info_pop,
  output logic                                 load_done,
  // read port
  input  logic                                 rd_en,
  input  conv_load_pkg::buf_idx_t              rd_buf_idx,
  input  logic [conv_load_pkg::BUF_ADR_W-1:0]  rd_adr,
  input  logic                                 rd_half,
  output logic                                 rd_valid,
  output conv_load_pkg::half_t                 rd_pixels
);
  import conv_load_pkg::*;

  localparam int HALF_W = PIXELS_PER_HALF * PIXEL_W;

  logic [DDR_WORD_W-1:0] rd_word [NUM_ROW_BUFS];  // registered output of each buffer
  logic [DDR_WORD_W-1:0] sel_word;
  buf_idx_t              rd_buf_q;
  logic                  rd_half_q;
  logic                  done_q;

  // every returned word consumes exactly one entry
  assign info_pop = ddr_rd_valid;

  // --------------------------------------------------
  // three dual-port row buffers
  // --------------------------------------------------
  for (genvar b = 0; b < NUM_ROW_BUFS; b++)
  begin : g_buf
    logic [DDR_WORD_W-1:0] mem [2**BUF_ADR_W];

    // write port, steered by the FIFO head
    always_ff @(posedge clk)
    begin
      if (ddr_rd_valid && info_head.buf_idx == buf_idx_t'(b))
        mem[info_head.buf_adr] <= ddr_rd_data;
    end

    // read port
    always_ff @(posedge clk)
    begin
      if (rd_en && rd_buf_idx == buf_idx_t'(b))
        rd_word[b] <= mem[rd_adr];
    end
  end

  // --------------------------------------------------
  // read select, one cycle after rd_en
  // --------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (reset)
      rd_valid <= 1'b0;
    else
      rd_valid <= rd_en;
  end

  always_ff @(posedge clk)
  begin
    if (rd_en)
    begin
      rd_buf_q  <= rd_buf_idx;
      rd_half_q <= rd_half;  // word select
    end
  end

  always_comb
  begin
    sel_word = '0;
    for (int i = 0; i < NUM_ROW_BUFS; i++)
    begin
      if (rd_buf_q == buf_idx_t'(i))
        sel_word = rd_word[i];
    end
  end

  // upper half holds pixels 32..63
  assign rd_pixels = rd_half_q ? sel_word[DDR_WORD_W-1 -: HALF_W] : sel_word[HALF_W-1:0];

  // --------------------------------------------------
  // job done, cycle after the last write
  // --------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (reset)
      done_q <= 1'b0;
    else
      done_q <= ddr_rd_valid && info_head.last;
  end

  assign load_done = done_q;

  // data never returns without a matching request
  a_valid_has_entry : assert property (@(posedge clk) disable iff (reset)
    ddr_rd_valid |-> !info_empty);

  a_buf_idx_range : assert property (@(posedge clk) disable iff (reset)
    ddr_rd_valid |-> info_head.buf_idx < NUM_ROW_BUFS);

endmodule

// ==== source/conv_input_load.sv ====
module conv_input_load (
  input  logic                                 clk,
  input  logic                                 reset,
  // job control
  input  logic                                 load_start,
  input  conv_load_pkg::load_cfg_t             load_cfg,
  output logic                                 load_busy,
  output logic                                 load_done,
  // DDR read side
  input  logic                                 ddr_ready,
  output logic                                 ddr_rd_en,
  output logic [conv_load_pkg::DDR_ADR_W-1:0]  ddr_rd_adr,
  input  logic                                 ddr_rd_valid,
  input  logic [conv_load_pkg::DDR_WORD_W-1:0] ddr_rd_data,
  // row buffer read port
  input  logic                                 rd_en,
  input  conv_load_pkg::buf_idx_t              rd_buf_idx,
  input  logic [conv_load_pkg::BUF_ADR_W-1:0]  rd_adr,
  input  logic                                 rd_half,
  output logic                                 rd_valid,
  output conv_load_pkg::half_t                 rd_pixels
);
  import conv_load_pkg::*;

  logic       info_push;
  load_info_t info_data;
  logic       info_full;
  logic       info_pop;
  load_info_t info_head;
  logic       info_empty;

  // --------------------------------------------------
  // request side
  // --------------------------------------------------
  load_sequencer i_load_sequencer (
    .clk        (clk),
    .reset      (reset),
    .load_start (load_start),
    .load_cfg   (load_cfg),
    .ddr_ready  (ddr_ready),
    .info_full  (info_full),
    .load_done  (load_done),   // closes the job
    .load_busy  (load_busy),
    .ddr_rd_en  (ddr_rd_en),
    .ddr_rd_adr (ddr_rd_adr),
    .info_push  (info_push),
    .info_data  (info_data)
  );

  // request order == return order, so a plain FIFO pairs them
  load_info_fifo i_load_info_fifo (
    .clk       (clk),
    .reset     (reset),
    .push      (info_push),
    .push_data (info_data),
    .pop       (info_pop),
    .head      (info_head),
    .full      (info_full),
    .empty     (info_empty)
  );

  // --------------------------------------------------
  // return side
  // --------------------------------------------------
  row_buffer_bank i_row_buffer_bank (
    .clk          (clk),
    .reset        (reset),
    .ddr_rd_valid (ddr_rd_valid),
    .ddr_rd_data  (ddr_rd_data),
    .info_head    (info_head),
    .info_empty   (info_empty),
    .info_pop     (info_pop),
    .load_done    (load_done),
    .rd_en        (rd_en),
    .rd_buf_idx   (rd_buf_idx),
    .rd_adr       (rd_adr),
    .rd_half      (rd_half),
    .rd_valid     (rd_valid),
    .rd_pixels    (rd_pixels)
  );

endmodule

// ==== dv/ddr_model.sv ====
module ddr_model (
  input  logic                                 clk,
  input  logic                                 reset,
  input  int                                   max_delay,  // upper bound of the random latency
  input  logic                                 rd_en,
  input  logic [conv_load_pkg::DDR_ADR_W-1:0]  rd_adr,
  output logic                                 rd_valid,
  output logic [conv_load_pkg::DDR_WORD_W-1:0] rd_data
);
  timeunit 1ns;
  timeprecision 100ps;
  import conv_load_pkg::*;

  logic [DDR_ADR_W-1:0] adr_q [$];  // pending reads, oldest first
  int                   due_q [$];
  int                   cyc;
  int                   last_due;
  int                   due;

  // address in both 16-bit halves of every lane, lane key on top
  function automatic logic [DDR_WORD_W-1:0] word_data(input logic [DDR_ADR_W-1:0] adr);
    logic [DDR_WORD_W-1:0] w;
    for (int i = 0; i < DDR_WORD_W / 32; i++)
      w[i*32 +: 32] = {adr, adr} ^ (32'h1f35_9e01 + 32'(i) * 32'h0101_0101);
    return w;
  endfunction

  initial
  begin
    rd_valid = 1'b0;
    rd_data  = '0;
  end

  // accept requests, due times never go backwards so data stays in order
  always @(posedge clk)
  begin
    if (reset)
    begin
      adr_q.delete();
      due_q.delete();
      cyc      = 0;
      last_due = 0;
    end
    else
    begin
      cyc = cyc + 1;
      if (rd_en)
      begin
        due = cyc + int'($urandom_range(max_delay, 1));
        if (due <= last_due)
          due = last_due + 1;  // one word per cycle on the return bus
        last_due = due;
        adr_q.push_back(rd_adr);
        due_q.push_back(due);
      end
    end
  end

  // return side, driven away from the sampling edge
  always @(negedge clk)
  begin
    if (reset || due_q.size() == 0 || due_q[0] > cyc)
      rd_valid <= 1'b0;
    else
    begin
      rd_valid <= 1'b1;
      rd_data  <= word_data(adr_q.pop_front());
      void'(due_q.pop_front());
    end
  end

endmodule

// ==== dv/conv_input_load_tb.sv ====
module conv_input_load_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import conv_load_pkg::*;

  localparam int DONE_TIMEOUT = 5000;  // cycles
  localparam int BUSY_TIMEOUT = 20;

  logic                  clk;
  logic                  reset;
  logic                  load_start;
  load_cfg_t             load_cfg;
  logic                  load_busy;
  logic                  load_done;
  logic                  ddr_ready;
  logic                  ddr_rd_en;
  logic [DDR_ADR_W-1:0]  ddr_rd_adr;
  logic                  ddr_rd_valid;
  logic [DDR_WORD_W-1:0] ddr_rd_data;
  logic                  rd_en;
  buf_idx_t              rd_buf_idx;
  logic [BUF_ADR_W-1:0]  rd_adr;
  logic                  rd_half;
  logic                  rd_valid;
  half_t                 rd_pixels;

  // reference state
  int                    max_delay;
  logic                  started;   // first real load_start seen
  logic                  new_job;
  logic [DDR_ADR_W-1:0]  job_base;
  logic [DDR_ADR_W-1:0]  exp_adr;
  int                    exp_total;
  int                    req_cnt;
  int                    done_cnt;
  logic [DDR_ADR_W-1:0]  ref_ddr [NUM_ROW_BUFS][2**BUF_ADR_W];  // DDR address behind each location
  int                    ref_cnt [NUM_ROW_BUFS];
  half_t                 exp_pixels;
  string                 phase;

  conv_input_load i_conv_input_load (
    .clk(clk), .reset(reset), .load_start(load_start), .load_cfg(load_cfg),
    .load_busy(load_busy), .load_done(load_done), .ddr_ready(ddr_ready),
    .ddr_rd_en(ddr_rd_en), .ddr_rd_adr(ddr_rd_adr), .ddr_rd_valid(ddr_rd_valid),
    .ddr_rd_data(ddr_rd_data), .rd_en(rd_en), .rd_buf_idx(rd_buf_idx), .rd_adr(rd_adr),
    .rd_half(rd_half), .rd_valid(rd_valid), .rd_pixels(rd_pixels)
  );

  ddr_model i_ddr_model (
    .clk(clk), .reset(reset), .max_delay(max_delay), .rd_en(ddr_rd_en),
    .rd_adr(ddr_rd_adr), .rd_valid(ddr_rd_valid), .rd_data(ddr_rd_data)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // --------------------------------------------------
  // error reporting
  // --------------------------------------------------
  task automatic stop_run();
    $display("Some tests failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic mismatch(input string what, input logic [DDR_WORD_W-1:0] exp_v,
                          input logic [DDR_WORD_W-1:0] act_v);
    $display("[FAIL] %s %s: expected %0h, actual %0h", phase, what, exp_v, act_v);
    stop_run();
  endtask

  task automatic report_error(input string what);
    $display("%s: %s", phase, what);
    stop_run();
  endtask

  // same lane pattern the DDR model returns
  function automatic half_t expected_half(input logic [DDR_ADR_W-1:0] adr, input logic upper);
    logic [DDR_WORD_W-1:0] w;
    for (int i = 0; i < DDR_WORD_W / 32; i++)
      w[i*32 +: 32] = {adr, adr} ^ (32'h1f35_9e01 + 32'(i) * 32'h0101_0101);
    return upper ? w[DDR_WORD_W-1 -: $bits(half_t)] : w[$bits(half_t)-1:0];
  endfunction

  always @(negedge clk)
    ddr_ready <= ($urandom_range(3, 0) != 0);  // high about 3 cycles in 4

  always @(posedge clk)
  begin
    if (new_job)
    begin
      exp_adr  <= job_base;
      req_cnt  <= 0;
      done_cnt <= 0;
    end
    else
    begin
      if (ddr_rd_en)
      begin
        exp_adr <= exp_adr + 1'b1;
        req_cnt <= req_cnt + 1;
      end
      if (load_done)
        done_cnt <= done_cnt + 1;
    end
    if (rd_en)
      exp_pixels <= expected_half(ref_ddr[rd_buf_idx][rd_adr], rd_half);
  end

  // --------------------------------------------------
  // checks
  // --------------------------------------------------
  a_idle : assert property (@(posedge clk) disable iff (reset)
    !started |-> !load_busy && !load_done && !ddr_rd_en && !rd_valid)
    else report_error("outputs active before the first load_start");
  a_req_adr : assert property (@(posedge clk) disable iff (reset)
    ddr_rd_en |-> ddr_rd_adr == exp_adr)
    else mismatch("request address", DDR_WORD_W'($sampled(exp_adr)),
                  DDR_WORD_W'($sampled(ddr_rd_adr)));
  a_ready : assert property (@(posedge clk) disable iff (reset) !ddr_ready |-> !ddr_rd_en)
    else report_error("request issued while ddr_ready was low");
  a_req_max : assert property (@(posedge clk) disable iff (reset)
    ddr_rd_en |-> req_cnt < exp_total)
    else report_error("more requests than the job holds");
  a_req_total : assert property (@(posedge clk) disable iff (reset)
    load_done |-> req_cnt == exp_total)
    else mismatch("requests before done", DDR_WORD_W'($sampled(exp_total)),
                  DDR_WORD_W'($sampled(req_cnt)));
  a_done_once : assert property (@(posedge clk) disable iff (reset) load_done |-> done_cnt == 0)
    else report_error("load_done pulsed twice in one job");
  // busy must stay high through the job and drop exactly with the done pulse
  a_busy_fall : assert property (@(posedge clk) disable iff (reset)
    load_done |-> $fell(load_busy))
    else report_error("load_busy did not fall together with load_done");
  a_start_busy : assert property (@(posedge clk) disable iff (reset)
    load_start && load_busy |=> load_busy)
    else report_error("load_start during a job dropped load_busy");
  a_rd_valid_hi : assert property (@(posedge clk) disable iff (reset) rd_en |=> rd_valid)
    else report_error("rd_valid missing one cycle after rd_en");
  a_rd_valid_lo : assert property (@(posedge clk) disable iff (reset) !rd_en |=> !rd_valid)
    else report_error("rd_valid without rd_en");
  a_rd_data : assert property (@(posedge clk) disable iff (reset)
    rd_valid |-> rd_pixels == exp_pixels)
    else mismatch("read data", DDR_WORD_W'($sampled(exp_pixels)),
                  DDR_WORD_W'($sampled(rd_pixels)));

  // --------------------------------------------------
  // stimulus
  // --------------------------------------------------
  function automatic load_cfg_t make_cfg(input logic [15:0] base, input logic [7:0] rows,
                                         input logic [7:0] nif, input logic [7:0] words);
    load_cfg_t c;
    c.base_adr = base;
    c.rows     = rows;
    c.nif      = nif;
    c.words    = words;
    c.spare    = '0;
    return c;
  endfunction

  // row r, map f, word w lives at base + (r*nif + f)*words + w, row r in buffer r mod 3
  task automatic build_reference(input load_cfg_t cfg);
    int b;
    for (int i = 0; i < NUM_ROW_BUFS; i++)
      ref_cnt[i] = 0;
    for (int r = 0; r < int'(cfg.rows); r++)
      for (int f = 0; f < int'(cfg.nif); f++)
        for (int w = 0; w < int'(cfg.words); w++)
        begin
          b = r % NUM_ROW_BUFS;
          ref_ddr[b][ref_cnt[b]] = DDR_ADR_W'(int'(cfg.base_adr)
                                   + (r * int'(cfg.nif) + f) * int'(cfg.words) + w);
          ref_cnt[b]++;
        end
  endtask

  task automatic run_job(input string name, input load_cfg_t cfg, input int delay_max);
    int n;
    phase = name;
    @(negedge clk);
    build_reference(cfg);
    max_delay  = delay_max;
    job_base   = cfg.base_adr;
    exp_total  = int'(cfg.rows) * int'(cfg.nif) * int'(cfg.words);
    load_cfg   = cfg;
    load_start = 1'b1;
    new_job    = 1'b1;
    started    = 1'b1;
    @(negedge clk);
    load_start = 1'b0;
    new_job    = 1'b0;
    repeat (5) @(negedge clk);
    load_cfg   = make_cfg(16'hffff, 8'd9, 8'd9, 8'd9);  // must be ignored
    load_start = 1'b1;
    @(negedge clk);
    load_start = 1'b0;
    n = 0;
    while (!load_done)
      if (n == DONE_TIMEOUT)
        report_error("timeout waiting for load_done");
      else
      begin
        n++;
        @(negedge clk);
      end
    n = 0;
    while (load_busy)
      if (n == BUSY_TIMEOUT)
        report_error("timeout waiting for load_busy to fall");
      else
      begin
        n++;
        @(negedge clk);
      end
  endtask

  // both halves of every location the last job wrote
  task automatic read_back(input string name);
    phase = name;
    for (int b = 0; b < NUM_ROW_BUFS; b++)
      for (int p = 0; p < ref_cnt[b]; p++)
        for (int h = 0; h < 2; h++)
        begin
          @(negedge clk);
          rd_en      = 1'b1;
          rd_buf_idx = buf_idx_t'(b);
          rd_adr     = BUF_ADR_W'(p);
          rd_half    = 1'(h);
        end
    @(negedge clk);
    rd_en = 1'b0;
    repeat (2) @(negedge clk);
  endtask

  initial
  begin
    void'($urandom(92));
    reset      = 1'b1;
    load_start = 1'b0;
    load_cfg   = '0;
    ddr_ready  = 1'b0;
    rd_en      = 1'b0;
    rd_buf_idx = '0;
    rd_adr     = '0;
    rd_half    = 1'b0;
    max_delay  = 6;
    started    = 1'b0;
    new_job    = 1'b0;
    job_base   = '0;
    exp_total  = 0;
    phase      = "reset";
    repeat (4) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    phase = "idle";
    repeat (10) @(negedge clk);
    run_job("job1", make_cfg(16'h0100, 8'd4, 8'd3, 8'd5), 6);
    read_back("job1 readback");
    // 7 rows, long latencies keep the FIFO near full
    run_job("job2", make_cfg(16'h3a20, 8'd7, 8'd2, 8'd6), 40);
    read_back("job2 readback");
    $display("All tests passed");
    $finish;
  end

endmodule

// ==== conv_input_load.f ====
source/conv_load_pkg.sv
source/load_sequencer.sv
source/load_info_fifo.sv
source/row_buffer_bank.sv
source/conv_input_load.sv
dv/ddr_model.sv
dv/conv_input_load_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the conv_input_load testbench with Verilator
set -e

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -j 0 \
  --timescale 1ns/100ps \
  --top-module conv_input_load_tb \
  --Mdir "$BUILD_DIR" \
  -f conv_input_load.f

# the log decides the result, a fatal stop leaves no pass line behind
"./$BUILD_DIR/Vconv_input_load_tb" > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "All tests passed" "$LOG"; then
  exit 0
fi
exit 1
